//--- Bender.yml
package:
  name: victim_cache

sources:
  - include_dirs:
      - include
    files:
      - design/vc_pkg.sv
      - design/vc_lookup_if.sv
      - design/vc_wb_if.sv
      - design/vc_line_store.sv
      - design/vc_lookup.sv
      - design/vc_writeback.sv
      - design/victim_cache.sv
      - target: test
        files:
          - tests/tb_victim_cache.sv

//--- design/vc_line_store.sv
`timescale 1ns/1ps
`include "vc_defs.svh"

module vc_line_store (
    input  logic                                CLK,
    input  logic                                rst_n,
    // Fill port from L1, one section per beat
    input  vc_pkg::vc_sect_t                    DATA_FROM_L1,
    input  logic [`VC_TAG_W+`VC_SECT_IDX_W-1:0] ADDR_FROM_L1,
    input  logic                                DIRTY_FROM_L1,
    input  logic                                WR_FROM_L1_VALID,
    output logic                                WR_FROM_L1_READY,
    // Search side and writeback side
    vc_lookup_if.store                          lk,
    vc_wb_if.store                              wb
);
    import vc_pkg::*;

    // Line memories
    vc_tag_t [`VC_ENTRIES-1:0] tag_mem;
    vc_sect_t                  data_mem [`VC_SLOTS];

    // Per entry status
    logic [`VC_ENTRIES-1:0]    valid;
    logic [`VC_ENTRIES-1:0]    dirty;

    // Fill position
    vc_ptr_t                   wr_ptr;
    vc_sect_idx_t              fill_sect;

    vc_idx_t                   wr_idx;
    vc_idx_t                   rd_idx;
    vc_slot_t                  fill_slot;
    logic                      fill_fire;
    logic                      fill_first;
    logic                      fill_last;
    logic                      full;
    logic                      empty;

    //////////////////////////////////////////////////
    // Occupancy
    //////////////////////////////////////////////////

    assign wr_idx = wr_ptr[`VC_IDX_W-1:0];
    assign rd_idx = wb.rd_ptr[`VC_IDX_W-1:0];

    // Same entry, other lap, every slot unretired
    assign full  = (wr_idx == rd_idx) && (wr_ptr[`VC_IDX_W] != wb.rd_ptr[`VC_IDX_W]);
    assign empty = (wr_ptr == wb.rd_ptr);

    assign WR_FROM_L1_READY = !full;

    //////////////////////////////////////////////////
    // Fill from L1
    //////////////////////////////////////////////////

    assign fill_fire  = WR_FROM_L1_VALID && WR_FROM_L1_READY;
    assign fill_first = (fill_sect == '0);
    assign fill_last  = (fill_sect == '1);
    // Section taken from the low address bits of the beat
    assign fill_slot  = {wr_idx, ADDR_FROM_L1[`VC_SECT_IDX_W-1:0]};

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            fill_sect <= '0;
            valid     <= '0;
            dirty     <= '0;
        end else begin
            // Head line fully handed to L2
            if (wb.retire) begin
                dirty[rd_idx] <= 1'b0;
            end
            // First beat claims the entry
            if (fill_fire && fill_first) begin
                valid[wr_idx] <= 1'b1;
                dirty[wr_idx] <= DIRTY_FROM_L1;
            end
            if (fill_fire) begin
                fill_sect <= fill_sect + 1'b1;
                // Line complete, move to the next slot
                if (fill_last) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_fire) begin
            data_mem[fill_slot] <= DATA_FROM_L1;
            if (fill_first) begin
                tag_mem[wr_idx] <= ADDR_FROM_L1[`VC_TAG_W+`VC_SECT_IDX_W-1:`VC_SECT_IDX_W];
            end
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    // Search side sees every tag at once
    assign lk.tags    = tag_mem;
    assign lk.valid   = valid;
    assign lk.wr_ptr  = wr_ptr;
    assign lk.rd_data = data_mem[lk.rd_slot];

    // Writeback side sees the head entry
    assign wb.empty      = empty;
    assign wb.head_dirty = dirty[rd_idx];
    assign wb.head_tag   = tag_mem[rd_idx];
    assign wb.beat_data  = data_mem[wb.beat_slot];

endmodule

//--- design/vc_lookup.sv
`timescale 1ns/1ps
`include "vc_defs.svh"

module vc_lookup (
    input  logic                                CLK,
    input  logic                                rst_n,
    input  logic [`VC_TAG_W+`VC_SECT_IDX_W-1:0] SEARCH_ADDR,
    vc_lookup_if.lookup                         lk,
    // Results back to L1, two edges after the search
    output logic                                VICTIM_HIT,
    output vc_pkg::vc_slot_t                    HIT_ADDRESS,
    output vc_pkg::vc_sect_t                    DATA_TO_L1
);
    import vc_pkg::*;

    // Stage 1 state
    logic [`VC_ENTRIES-1:0] match_q;
    vc_sect_idx_t           sect_q;

    vc_idx_t                wr_idx;
    vc_idx_t                hit_idx;
    vc_slot_t               hit_slot;
    logic                   hit_any;

    //////////////////////////////////////////////////
    // Stage 1, compare against every entry
    //////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            match_q <= '0;
            sect_q  <= '0;
        end else begin
            for (int i = 0; i < `VC_ENTRIES; i++) begin
                match_q[i] <= lk.valid[i] &&
                    (lk.tags[i] == SEARCH_ADDR[`VC_TAG_W+`VC_SECT_IDX_W-1:`VC_SECT_IDX_W]);
            end
            sect_q <= SEARCH_ADDR[`VC_SECT_IDX_W-1:0];
        end
    end

    //////////////////////////////////////////////////
    // Stage 2, newest matching entry
    //////////////////////////////////////////////////

    assign wr_idx  = lk.wr_ptr[`VC_IDX_W-1:0];
    assign hit_any = |match_q;

    // Oldest candidate first, so the entry just below wr_ptr wins
    always_comb begin
        vc_idx_t cand;
        hit_idx = '0;
        for (int k = `VC_ENTRIES; k >= 1; k--) begin
            cand = vc_idx_t'(wr_idx - k);
            if (match_q[cand]) begin
                hit_idx = cand;
            end
        end
    end

    assign hit_slot   = {hit_idx, sect_q};
    assign lk.rd_slot = hit_slot;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            VICTIM_HIT  <= 1'b0;
            HIT_ADDRESS <= '0;
            DATA_TO_L1  <= '0;
        end else begin
            VICTIM_HIT  <= hit_any;
            HIT_ADDRESS <= hit_slot;
            // Miss keeps the last delivered word
            if (hit_any) begin
                DATA_TO_L1 <= lk.rd_data;
            end
        end
    end

endmodule

//--- design/vc_lookup_if.sv
`timescale 1ns/1ps
`include "vc_defs.svh"

interface vc_lookup_if;
    import vc_pkg::*;

    // Tag array and valid bits, straight from the store
    vc_tag_t [`VC_ENTRIES-1:0] tags;
    logic [`VC_ENTRIES-1:0] valid;
    // Newest entry sits just below this pointer
    vc_ptr_t wr_ptr;

    // Data word select and its combinational read data
    vc_slot_t rd_slot;
    vc_sect_t rd_data;

    modport store (output tags, output valid, output wr_ptr,
                   input rd_slot, output rd_data);

    modport lookup (input tags, input valid, input wr_ptr,
                    output rd_slot, input rd_data);

endinterface

//--- design/vc_pkg.sv
`include "vc_defs.svh"

package vc_pkg;

    // Entry number inside the cache
    typedef logic [`VC_IDX_W-1:0] vc_idx_t;

    // FIFO pointer, entry number plus wrap bit on top
    typedef logic [`VC_IDX_W:0] vc_ptr_t;

    // Section number within a line
    typedef logic [`VC_SECT_IDX_W-1:0] vc_sect_idx_t;

    // Entry then section, addresses one data word
    typedef logic [`VC_IDX_W+`VC_SECT_IDX_W-1:0] vc_slot_t;

    // Line address as stored in the tag memory
    typedef logic [`VC_TAG_W-1:0] vc_tag_t;

    // Payload types
    typedef logic [`VC_SECT_W-1:0] vc_sect_t;
    typedef logic [`VC_L2_W-1:0] vc_beat_t;

    // Beat number within one line writeback
    typedef logic [`VC_BEAT_IDX_W-1:0] vc_beat_idx_t;

    // Writeback engine states
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_SEND,
        WB_WAIT
    } vc_wb_state_e;

endpackage

//--- design/vc_wb_if.sv
`timescale 1ns/1ps

interface vc_wb_if;
    import vc_pkg::*;

    // FIFO head, owned by the writeback engine
    vc_ptr_t rd_ptr;
    // Word read for the beat being loaded
    vc_slot_t beat_slot;
    // One cycle pulse, clears dirty of the head entry
    logic retire;

    // Status of the head entry
    logic empty;
    logic head_dirty;
    vc_tag_t head_tag;
    vc_sect_t beat_data;

    modport store (input rd_ptr, input beat_slot, input retire,
                   output empty, output head_dirty, output head_tag,
                   output beat_data);

    modport wb (output rd_ptr, output beat_slot, output retire,
                input empty, input head_dirty, input head_tag,
                input beat_data);

endinterface

//--- design/vc_writeback.sv
`timescale 1ns/1ps
`include "vc_defs.svh"

module vc_writeback (
    input  logic                     CLK,
    input  logic                     rst_n,
    vc_wb_if.wb                      wb,
    // L2 write port
    input  logic                     WR_TO_L2_READY,
    output logic                     WR_TO_L2_VALID,
    output logic [`VC_L2_ADDR_W-1:0] WR_ADDR_TO_L2,
    output vc_pkg::vc_beat_t         DATA_TO_L2,
    input  logic                     WR_COMPLETE
);
    import vc_pkg::*;

    vc_wb_state_e state;
    vc_ptr_t      rd_ptr;
    // Next beat to load into the output register
    vc_beat_idx_t beat_cnt;
    // Output register holds the final beat of the line
    logic         last_beat;
    logic         out_valid;

    logic         start;
    logic         skip;
    logic         load;
    logic         accept;
    logic         retire;
    vc_sect_idx_t beat_sect;
    logic [`VC_BEAT_IDX_W-`VC_SECT_IDX_W-1:0] beat_half;

    //////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////

    assign start  = (state == WB_IDLE) && !wb.empty && wb.head_dirty;
    // Clean head needs no L2 traffic
    assign skip   = (state == WB_IDLE) && !wb.empty && !wb.head_dirty;
    // Register free or draining this cycle
    assign load   = (state == WB_SEND) && !last_beat && (!out_valid || WR_TO_L2_READY);
    assign accept = out_valid && WR_TO_L2_READY;
    // Completion only counts while waiting for it
    assign retire = (state == WB_WAIT) && WR_COMPLETE;

    // Section in the upper beat bits, half in the lower
    assign beat_sect = beat_cnt[`VC_BEAT_IDX_W-1 -: `VC_SECT_IDX_W];
    assign beat_half = beat_cnt[`VC_BEAT_IDX_W-`VC_SECT_IDX_W-1:0];

    assign wb.rd_ptr    = rd_ptr;
    assign wb.beat_slot = {rd_ptr[`VC_IDX_W-1:0], beat_sect};
    assign wb.retire    = retire;

    //////////////////////////////////////////////////
    // FSM and read pointer
    //////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state     <= WB_IDLE;
            rd_ptr    <= '0;
            beat_cnt  <= '0;
            last_beat <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (start) begin
                        state    <= WB_SEND;
                        beat_cnt <= '0;
                    end else if (skip) begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                end
                WB_SEND: begin
                    // Final beat taken by L2
                    if (accept && last_beat) begin
                        state     <= WB_WAIT;
                        last_beat <= 1'b0;
                    end
                end
                WB_WAIT: begin
                    if (retire) begin
                        state  <= WB_IDLE;
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                end
                default: state <= WB_IDLE;
            endcase

            if (load) begin
                beat_cnt  <= beat_cnt + 1'b1;
                last_beat <= (beat_cnt == '1);
            end

            // Output register occupancy
            if (load) begin
                out_valid <= 1'b1;
            end else if (accept) begin
                out_valid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    // Holds steady under back-pressure
    always_ff @(posedge CLK) begin
        if (load) begin
            WR_ADDR_TO_L2 <= {wb.head_tag, {(`VC_L2_ADDR_W-`VC_TAG_W){1'b0}}};
            DATA_TO_L2    <= wb.beat_data[beat_half*`VC_L2_W +: `VC_L2_W];
        end
    end

    assign WR_TO_L2_VALID = out_valid;

endmodule

//--- design/victim_cache.sv
`timescale 1ns/1ps
`include "vc_defs.svh"

module victim_cache (
    input  logic                                CLK,
    input  logic                                rst_n,
    // Fill port from L1
    input  vc_pkg::vc_sect_t                    DATA_FROM_L1,
    input  logic [`VC_TAG_W+`VC_SECT_IDX_W-1:0] ADDR_FROM_L1,
    input  logic                                DIRTY_FROM_L1,
    input  logic                                WR_FROM_L1_VALID,
    output logic                                WR_FROM_L1_READY,
    // Search port from L1
    input  logic [`VC_TAG_W+`VC_SECT_IDX_W-1:0] SEARCH_ADDR,
    output logic                                VICTIM_HIT,
    output vc_pkg::vc_slot_t                    HIT_ADDRESS,
    output vc_pkg::vc_sect_t                    DATA_TO_L1,
    // Write port to L2
    input  logic                                WR_TO_L2_READY,
    output logic                                WR_TO_L2_VALID,
    output logic [`VC_L2_ADDR_W-1:0]            WR_ADDR_TO_L2,
    output vc_pkg::vc_beat_t                    DATA_TO_L2,
    input  logic                                WR_COMPLETE
);

    // Store to search pipeline
    vc_lookup_if lk_if ();
    // Store to writeback engine
    vc_wb_if     wb_if ();

    // Memories, fill port, full and empty
    vc_line_store u_store (
        .CLK              (CLK),
        .rst_n            (rst_n),
        .DATA_FROM_L1     (DATA_FROM_L1),
        .ADDR_FROM_L1     (ADDR_FROM_L1),
        .DIRTY_FROM_L1    (DIRTY_FROM_L1),
        .WR_FROM_L1_VALID (WR_FROM_L1_VALID),
        .WR_FROM_L1_READY (WR_FROM_L1_READY),
        .lk               (lk_if.store),
        .wb               (wb_if.store)
    );

    // Two stage search
    vc_lookup u_lookup (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .SEARCH_ADDR (SEARCH_ADDR),
        .lk          (lk_if.lookup),
        .VICTIM_HIT  (VICTIM_HIT),
        .HIT_ADDRESS (HIT_ADDRESS),
        .DATA_TO_L1  (DATA_TO_L1)
    );

    // Dirty line drain to L2
    vc_writeback u_writeback (
        .CLK            (CLK),
        .rst_n          (rst_n),
        .wb             (wb_if.wb),
        .WR_TO_L2_READY (WR_TO_L2_READY),
        .WR_TO_L2_VALID (WR_TO_L2_VALID),
        .WR_ADDR_TO_L2  (WR_ADDR_TO_L2),
        .DATA_TO_L2     (DATA_TO_L2),
        .WR_COMPLETE    (WR_COMPLETE)
    );

endmodule

//--- filelist.f
+incdir+include
design/vc_pkg.sv
design/vc_lookup_if.sv
design/vc_wb_if.sv
design/vc_line_store.sv
design/vc_lookup.sv
design/vc_writeback.sv
design/victim_cache.sv
tests/tb_victim_cache.sv

//--- include/vc_defs.svh
`ifndef VC_DEFS_SVH
`define VC_DEFS_SVH

// Entry index width, 4 entries
`define VC_IDX_W 2
// Section index width, 2 sections per line
`define VC_SECT_IDX_W 1
// One line section
`define VC_SECT_W 64
// Line address, byte address without the 4 offset bits
`define VC_TAG_W 28
// L2 write bus
`define VC_L2_W 32
`define VC_L2_ADDR_W 30

// Derived sizes
`define VC_ENTRIES (1 << `VC_IDX_W)
`define VC_SECTS (1 << `VC_SECT_IDX_W)
`define VC_SLOTS (`VC_ENTRIES * `VC_SECTS)
// Section number followed by the half within the section
`define VC_BEAT_IDX_W (`VC_SECT_IDX_W + $clog2(`VC_SECT_W / `VC_L2_W))

`endif

//--- tests/tb_victim_cache.sv
`timescale 1ns/1ps
`include "vc_defs.svh"

module tb_victim_cache;
    import vc_pkg::*;

    localparam int entries = `VC_ENTRIES;
    localparam int addr_w = `VC_TAG_W + `VC_SECT_IDX_W;
    localparam int beats_per_line = `VC_SECTS * `VC_SECT_W / `VC_L2_W;
    // Run length of 15 lines filled and 29 searches
    localparam int num_lines = 15;
    localparam int num_searches = 29;
    localparam int watchdog_cycles = num_lines * 60 + num_searches * 4 + 200;

    logic                     CLK;
    logic                     rst_n;
    vc_sect_t                 DATA_FROM_L1;
    logic [addr_w-1:0]        ADDR_FROM_L1;
    logic                     DIRTY_FROM_L1;
    logic                     WR_FROM_L1_VALID;
    logic                     WR_FROM_L1_READY;
    logic [addr_w-1:0]        SEARCH_ADDR;
    logic                     VICTIM_HIT;
    vc_slot_t                 HIT_ADDRESS;
    vc_sect_t                 DATA_TO_L1;
    logic                     WR_TO_L2_READY;
    logic                     WR_TO_L2_VALID;
    logic [`VC_L2_ADDR_W-1:0] WR_ADDR_TO_L2;
    vc_beat_t                 DATA_TO_L2;
    logic                     WR_COMPLETE;

    // Model of the cache contents
    vc_tag_t  m_tag [entries];
    vc_sect_t m_data [entries][`VC_SECTS];
    logic     m_valid [entries];
    int       m_wr;
    vc_sect_t m_last;

    // L2 scoreboard
    logic [`VC_L2_ADDR_W-1:0] exp_addr_q [$];
    vc_beat_t                 exp_data_q [$];
    int                       beats_in_line;
    logic                     wait_complete;
    logic                     hold_complete;

    logic [addr_w-1:0] search_q [$];
    vc_tag_t           tag_hist [$];
    vc_tag_t           dup_tag;

    // All ports share their names with the DUT
    victim_cache dut_i (.*);

    //////////////////////////////////////////////////
    // Reference functions
    //////////////////////////////////////////////////

    // Newest valid entry holding the tag or -1 on a miss
    function automatic int newest_entry(input vc_tag_t tag);
        int idx;
        newest_entry = -1;
        for (int k = 1; k <= entries; k++) begin
            idx = (m_wr + entries - k) % entries;
            if (newest_entry < 0 && m_valid[idx] && m_tag[idx] == tag) begin
                newest_entry = idx;
            end
        end
    endfunction

    // Beat n of a line in section order with the low half first
    function automatic vc_beat_t expected_beat(input int entry, input int n);
        vc_sect_t sect;
        sect = m_data[entry][n / 2];
        return sect[(n % 2) * `VC_L2_W +: `VC_L2_W];
    endfunction

    // Line base byte address turned into a 32-bit word number
    function automatic logic [`VC_L2_ADDR_W-1:0] expected_l2_addr(input vc_tag_t tag);
        logic [`VC_TAG_W+3:0] byte_addr;
        byte_addr = {tag, 4'h0};
        return byte_addr[`VC_TAG_W+3:2];
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("FAIL time=%0t %s expected=0x%0h actual=0x%0h", $time, name, exp, act);
        $display("STATUS: FAIL");
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic report_error(input string what);
        $display("ERROR time=%0t %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "%s", what);
    endtask

    //////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////

    // One line as two beats in random section order
    task automatic fill_line(input vc_tag_t tag, input logic dirty);
        int slot;
        int first;
        int s;
        slot  = m_wr % entries;
        first = $urandom % 2;
        for (int b = 0; b < `VC_SECTS; b++) begin
            s = b ^ first;
            m_data[slot][s] = {$urandom, $urandom};
            @(negedge CLK);
            WR_FROM_L1_VALID = 1'b1;
            ADDR_FROM_L1     = {tag, vc_sect_idx_t'(s)};
            DATA_FROM_L1     = m_data[slot][s];
            DIRTY_FROM_L1    = dirty;
            // Held until the store can take it
            while (!WR_FROM_L1_READY) @(negedge CLK);
            @(posedge CLK);
        end
        @(negedge CLK);
        WR_FROM_L1_VALID = 1'b0;
        m_tag[slot]   = tag;
        m_valid[slot] = 1'b1;
        m_wr++;
        tag_hist.push_back(tag);
        // Dirty lines owe L2 one full line
        if (dirty) begin
            for (int n = 0; n < beats_per_line; n++) begin
                exp_addr_q.push_back(expected_l2_addr(tag));
                exp_data_q.push_back(expected_beat(slot, n));
            end
        end
    endtask

    task automatic queue_line_search(input vc_tag_t tag);
        for (int s = 0; s < `VC_SECTS; s++) begin
            search_q.push_back({tag, vc_sect_idx_t'(s)});
        end
    endtask

    // Back to back searches with each result checked two edges later
    task automatic run_searches();
        int       total;
        int       idx;
        logic     hit;
        vc_slot_t slot;
        vc_sect_t data;
        int       exp_idx [$];
        vc_slot_t exp_slot [$];
        vc_sect_t exp_data [$];
        total = search_q.size();
        for (int i = 0; i < total + 2; i++) begin
            @(negedge CLK);
            if (i >= 2) begin
                idx  = exp_idx.pop_front();
                slot = exp_slot.pop_front();
                data = exp_data.pop_front();
                hit  = (idx >= 0);
                assert (VICTIM_HIT == hit) else report_mismatch("VICTIM_HIT", hit, VICTIM_HIT);
                if (hit) begin
                    assert (HIT_ADDRESS == slot)
                        else report_mismatch("HIT_ADDRESS", slot, HIT_ADDRESS);
                end
                assert (DATA_TO_L1 == data) else report_mismatch("DATA_TO_L1", data, DATA_TO_L1);
            end
            if (i < total) begin
                SEARCH_ADDR = search_q.pop_front();
                idx = newest_entry(SEARCH_ADDR[addr_w-1:`VC_SECT_IDX_W]);
                exp_idx.push_back(idx);
                exp_slot.push_back({vc_idx_t'(idx), SEARCH_ADDR[`VC_SECT_IDX_W-1:0]});
                // Miss leaves the last word on DATA_TO_L1
                if (idx >= 0) begin
                    m_last = m_data[idx][SEARCH_ADDR[`VC_SECT_IDX_W-1:0]];
                end
                exp_data.push_back(m_last);
            end
        end
    endtask

    task automatic wait_drained();
        while (exp_addr_q.size() != 0 || wait_complete) @(negedge CLK);
        repeat (4) @(negedge CLK);
    endtask

    //////////////////////////////////////////////////
    // Clock, L2 model, comparator, watchdog
    //////////////////////////////////////////////////

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // Random back-pressure with ready about three cycles in four
    initial begin
        forever begin
            @(negedge CLK);
            WR_TO_L2_READY = ($urandom % 4) != 0;
        end
    end

    // Completion pulse a few cycles after a full line
    initial begin
        forever begin
            @(negedge CLK);
            if (wait_complete && !hold_complete) begin
                repeat ($urandom % 4) @(negedge CLK);
                WR_COMPLETE = 1'b1;
                @(negedge CLK);
                WR_COMPLETE = 1'b0;
            end
        end
    end

    always @(posedge CLK) begin : compare_l2
        logic [`VC_L2_ADDR_W-1:0] a;
        vc_beat_t                 d;
        if (rst_n && WR_TO_L2_VALID && WR_TO_L2_READY) begin
            assert (!wait_complete)
                else report_error("L2 beat accepted before the previous line completed");
            assert (exp_addr_q.size() != 0) else report_error("L2 beat with no dirty line pending");
            a = exp_addr_q.pop_front();
            d = exp_data_q.pop_front();
            assert (WR_ADDR_TO_L2 == a) else report_mismatch("WR_ADDR_TO_L2", a, WR_ADDR_TO_L2);
            assert (DATA_TO_L2 == d) else report_mismatch("DATA_TO_L2", d, DATA_TO_L2);
            beats_in_line++;
            if (beats_in_line == beats_per_line) begin
                beats_in_line = 0;
                wait_complete = 1'b1;
            end
        end
        if (rst_n && WR_COMPLETE) begin
            wait_complete = 1'b0;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge CLK);
        report_error("watchdog expired before the tests finished");
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h9af5_2dab));
        rst_n            = 1'b0;
        DATA_FROM_L1     = '0;
        ADDR_FROM_L1     = '0;
        DIRTY_FROM_L1    = 1'b0;
        WR_FROM_L1_VALID = 1'b0;
        SEARCH_ADDR      = '0;
        WR_TO_L2_READY   = 1'b0;
        WR_COMPLETE      = 1'b0;
        m_wr             = 0;
        m_last           = '0;
        beats_in_line    = 0;
        wait_complete    = 1'b0;
        hold_complete    = 1'b0;
        for (int i = 0; i < entries; i++) begin
            m_valid[i] = 1'b0;
        end
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;

        // Reset state
        @(negedge CLK);
        assert (WR_FROM_L1_READY == 1'b1)
            else report_mismatch("WR_FROM_L1_READY", 1, WR_FROM_L1_READY);
        assert (VICTIM_HIT == 1'b0) else report_mismatch("VICTIM_HIT", 0, VICTIM_HIT);
        assert (WR_TO_L2_VALID == 1'b0) else report_mismatch("WR_TO_L2_VALID", 0, WR_TO_L2_VALID);

        // Clean lines then resident and absent searches
        for (int i = 0; i < 4; i++) fill_line(vc_tag_t'($urandom), 1'b0);
        for (int i = 0; i < 4; i++) queue_line_search(tag_hist[i]);
        search_q.push_back({vc_tag_t'($urandom), vc_sect_idx_t'(0)});
        search_q.push_back({vc_tag_t'($urandom), vc_sect_idx_t'(1)});
        run_searches();

        // Dirty writeback mixed with a clean skip
        fill_line(vc_tag_t'($urandom), 1'b1);
        fill_line(vc_tag_t'($urandom), 1'b0);
        fill_line(vc_tag_t'($urandom), 1'b1);
        fill_line(vc_tag_t'($urandom), 1'b1);
        wait_drained();

        // Four unretired lines fill every slot
        hold_complete = 1'b1;
        for (int i = 0; i < 4; i++) fill_line(vc_tag_t'($urandom), 1'b1);
        repeat (8) begin
            @(negedge CLK);
            assert (WR_FROM_L1_READY == 1'b0)
                else report_mismatch("WR_FROM_L1_READY", 0, WR_FROM_L1_READY);
        end
        hold_complete = 1'b0;
        while (!WR_FROM_L1_READY) @(negedge CLK);
        // Lands in the slot just retired
        fill_line(vc_tag_t'($urandom), 1'b0);
        queue_line_search(tag_hist[tag_hist.size()-1]);
        run_searches();
        wait_drained();

        // Same tag twice then every tag seen so far
        dup_tag = vc_tag_t'($urandom);
        fill_line(dup_tag, 1'b0);
        fill_line(dup_tag, 1'b0);
        queue_line_search(dup_tag);
        foreach (tag_hist[i]) search_q.push_back({tag_hist[i], vc_sect_idx_t'(0)});
        run_searches();
        wait_drained();

        $display("STATUS: PASS");
        $finish;
    end

endmodule
